// ==== tb/axil_sram_patterns.txt ====
// op(0 wr, 1 rd, 2 both) addr wdata wstrb exp_rdata exp_resp
// ties alternate read first, then write
0 00000000 1122334455667788 ff 0000000000000000 0
1 00000000 0000000000000000 00 1122334455667788 0
0 00000008 0123456789abcdef ff 0000000000000000 0
0 00000008 aaaaaaaaaaaaaaaa 0f 0000000000000000 0
1 00000008 0000000000000000 00 01234567aaaaaaaa 0
0 00000008 5555555555555555 a0 0000000000000000 0
1 00000008 0000000000000000 00 55235567aaaaaaaa 0
0 00000800 ffffffffffffffff ff 0000000000000000 3
1 00000800 0000000000000000 00 0000000000000000 3
1 00000000 0000000000000000 00 1122334455667788 0
0 00000010 0000000000000010 ff 0000000000000000 0
2 00000010 cafef00ddeadbeef ff 0000000000000010 0
2 00000010 0badc0de12345678 ff 0badc0de12345678 0
2 00000010 1111111111111111 ff 0badc0de12345678 0
1 00000010 0000000000000000 00 1111111111111111 0
2 00001000 0123456789abcdef ff 0000000000000000 3

// ==== compile.f ====
+incdir+rtl
rtl/axil_sram_pkg.sv
rtl/axil_write_ctrl.sv
rtl/axil_read_ctrl.sv
rtl/sram_bank_arb.sv
rtl/axil_sram_top.sv
tb/axil_sram_checker.sv
tb/tb_axil_sram.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_axil_sram -o sim_axil_sram

./obj_dir/sim_axil_sram > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "run_sim: failure reported"
  exit 1
fi
echo "run_sim: no failure reported"

// ==== tb/tb_axil_sram.sv ====
// Testbench top with clock, reset, LFSR stalls, pattern-file driver, watchdog and closing report
`include "axil_sram_params.svh"

module tb_axil_sram
  import axil_sram_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NPAT = 16;
  localparam int FIELDS = 6;

  logic clk;
  logic rst;
  logic i_awvalid, i_wvalid, i_bready, i_arvalid, i_rready;
  logic o_awready, o_wready, o_bvalid, o_arready, o_rvalid;
  logic [`AXIL_ADDR_W-1:0] i_awaddr, i_araddr;
  logic [2:0] i_awprot, i_arprot;
  logic [`AXIL_DATA_W-1:0] i_wdata, o_rdata;
  logic [`AXIL_STRB_W-1:0] i_wstrb;
  axil_resp_e o_bresp, o_rresp;

  logic [63:0] pat [0:NPAT*FIELDS-1];
  logic [31:0] lfsr;
  int tb_errs;

  axil_sram_top dut0 (.*);

  axil_sram_checker chk0 (
    .clk(clk), .rst(rst),
    .o_bvalid(o_bvalid), .i_bready(i_bready), .o_bresp(o_bresp),
    .o_rvalid(o_rvalid), .i_rready(i_rready), .o_rdata(o_rdata), .o_rresp(o_rresp)
  );

  // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Random response stalls, one LFSR bit per channel per cycle
  initial begin
    lfsr = 32'hbe03_4e2b;
    forever begin
      @(posedge clk);
      #2;
      i_bready = lfsr[0];
      lfsr = lfsr_next(lfsr);
      i_rready = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  end

  task automatic run_txn(input logic [1:0] op, input logic [31:0] addr,
                         input logic [63:0] wdata, input logic [7:0] wstrb);
    logic aw_on;
    logic ar_on;
    logic w_done;
    logic r_done;
    aw_on = (op != 2'd1);
    ar_on = (op != 2'd0);
    @(posedge clk);
    #2;
    i_awvalid = aw_on;
    i_wvalid  = aw_on;
    i_awaddr  = addr;
    i_wdata   = wdata;
    i_wstrb   = wstrb;
    i_arvalid = ar_on;
    i_araddr  = addr;
    while (aw_on || ar_on) begin
      @(negedge clk);
      w_done = aw_on && o_awready && o_wready;
      r_done = ar_on && o_arready;
      @(posedge clk);
      #2;
      if (w_done) begin
        i_awvalid = 1'b0;
        i_wvalid  = 1'b0;
        aw_on     = 1'b0;
      end
      if (r_done) begin
        i_arvalid = 1'b0;
        ar_on     = 1'b0;
      end
    end
    // Let both responses drain so a later tie starts from a clean state
    @(negedge clk);
    while (o_bvalid || o_rvalid) @(negedge clk);
  endtask

  initial begin
    #(NPAT * 40 * 40);
    $display("Timeout: transactions did not complete within the expected time");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    logic [1:0] op;
    tb_errs = 0;
    rst = 1'b1;
    i_awvalid = 1'b0;
    i_wvalid  = 1'b0;
    i_arvalid = 1'b0;
    i_bready  = 1'b0;
    i_rready  = 1'b0;
    i_awaddr  = '0;
    i_araddr  = '0;
    i_awprot  = 3'd0;
    i_arprot  = 3'd0;
    i_wdata   = '0;
    i_wstrb   = '0;
    $readmemh("tb/axil_sram_patterns.txt", pat);
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    @(negedge clk);
    if (o_awready || o_wready || o_bvalid || o_arready || o_rvalid) begin
      $display("ERR reset: expected 0, awready %h wready %h bvalid %h arready %h rvalid %h",
               o_awready, o_wready, o_bvalid, o_arready, o_rvalid);
      tb_errs++;
    end
    for (int i = 0; i < NPAT; i++) begin
      op = pat[i*FIELDS][1:0];
      if (op != 2'd1) chk0.exp_b.push_back(pat[i*FIELDS+5][1:0]);
      if (op != 2'd0) chk0.exp_r.push_back({pat[i*FIELDS+5][1:0], pat[i*FIELDS+4]});
      run_txn(op, pat[i*FIELDS+1][31:0], pat[i*FIELDS+2], pat[i*FIELDS+3][7:0]);
    end
    if (chk0.exp_b.size() != 0 || chk0.exp_r.size() != 0) begin
      $display("Expected responses never arrived: %0d on B, %0d on R",
               chk0.exp_b.size(), chk0.exp_r.size());
      tb_errs++;
    end
    $display("Errors: driver %0d, checker %0d", tb_errs, chk0.err_count);
    if (tb_errs == 0 && chk0.err_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== tb/axil_sram_checker.sv ====
// Response checker comparing B and R channels with expected queues and checking hold stability
`include "axil_sram_params.svh"

module axil_sram_checker
  import axil_sram_pkg::*;
(
  input logic                    clk,
  input logic                    rst,
  input logic                    o_bvalid,
  input logic                    i_bready,
  input axil_resp_e              o_bresp,
  input logic                    o_rvalid,
  input logic                    i_rready,
  input logic [`AXIL_DATA_W-1:0] o_rdata,
  input axil_resp_e              o_rresp
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [1:0]  exp_b [$];
  logic [65:0] exp_r [$];
  int err_count = 0;

  logic        b_held;
  logic        r_held;
  logic [1:0]  b_last;
  logic [65:0] r_last;
  logic [65:0] r_exp;

  // Sampled mid-cycle where both DUT outputs and driven inputs are settled
  always @(negedge clk) begin
    if (rst) begin
      b_held = 1'b0;
      r_held = 1'b0;
    end else begin
      if (b_held && (!o_bvalid || o_bresp != b_last)) begin
        $display("ERR bresp stall: expected %h, observed valid %h resp %h",
                 b_last, o_bvalid, o_bresp);
        err_count++;
      end
      if (r_held && (!o_rvalid || {o_rresp, o_rdata} != r_last)) begin
        $display("ERR rdata stall: expected %h, observed valid %h value %h",
                 r_last, o_rvalid, {o_rresp, o_rdata});
        err_count++;
      end
      b_held = o_bvalid && !i_bready;
      r_held = o_rvalid && !i_rready;
      b_last = o_bresp;
      r_last = {o_rresp, o_rdata};

      if (o_bvalid && i_bready) begin
        if (exp_b.size() == 0) begin
          $display("A write response arrived with no write outstanding");
          err_count++;
        end else if (exp_b[0] != o_bresp) begin
          $display("ERR bresp: expected %h, observed %h", exp_b[0], o_bresp);
          err_count++;
          void'(exp_b.pop_front());
        end else begin
          void'(exp_b.pop_front());
        end
      end

      if (o_rvalid && i_rready) begin
        if (exp_r.size() == 0) begin
          $display("A read response arrived with no read outstanding");
          err_count++;
        end else begin
          r_exp = exp_r.pop_front();
          if (r_exp[63:0] != o_rdata) begin
            $display("ERR rdata: expected %h, observed %h", r_exp[63:0], o_rdata);
            err_count++;
          end
          if (r_exp[65:64] != o_rresp) begin
            $display("ERR rresp: expected %h, observed %h", r_exp[65:64], o_rresp);
            err_count++;
          end
        end
      end
    end
  end

endmodule

// ==== rtl/axil_sram_top.sv ====
// Top level of the AXI-lite SRAM slave with write and read controllers and the bank arbiter
`include "axil_sram_params.svh"

module axil_sram_top
  import axil_sram_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,

  input  logic                    i_awvalid,
  output logic                    o_awready,
  input  logic [`AXIL_ADDR_W-1:0] i_awaddr,
  input  logic [2:0]              i_awprot,

  input  logic                    i_wvalid,
  output logic                    o_wready,
  input  logic [`AXIL_DATA_W-1:0] i_wdata,
  input  logic [`AXIL_STRB_W-1:0] i_wstrb,

  output logic                    o_bvalid,
  input  logic                    i_bready,
  output axil_resp_e              o_bresp,

  input  logic                    i_arvalid,
  output logic                    o_arready,
  input  logic [`AXIL_ADDR_W-1:0] i_araddr,
  input  logic [2:0]              i_arprot,

  output logic                    o_rvalid,
  input  logic                    i_rready,
  output logic [`AXIL_DATA_W-1:0] o_rdata,
  output axil_resp_e              o_rresp
);

  logic                    wr_req;
  logic [`AXIL_ADDR_W-1:0] wr_addr;
  logic [`AXIL_DATA_W-1:0] wr_data;
  logic [`AXIL_STRB_W-1:0] wr_strb;
  logic                    wr_gnt;
  axil_resp_e              wr_resp;

  logic                    rd_req;
  logic [`AXIL_ADDR_W-1:0] rd_addr;
  logic                    rd_gnt;
  axil_resp_e              rd_resp;
  logic [`AXIL_DATA_W-1:0] rd_data;

  axil_write_ctrl u_write_ctrl (
    .clk       (clk),
    .rst       (rst),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_awaddr  (i_awaddr),
    .i_awprot  (i_awprot),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .i_wdata   (i_wdata),
    .i_wstrb   (i_wstrb),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_bresp   (o_bresp),
    .o_wr_req  (wr_req),
    .o_wr_addr (wr_addr),
    .o_wr_data (wr_data),
    .o_wr_strb (wr_strb),
    .i_wr_gnt  (wr_gnt),
    .i_wr_resp (wr_resp)
  );

  axil_read_ctrl u_read_ctrl (
    .clk       (clk),
    .rst       (rst),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .i_araddr  (i_araddr),
    .i_arprot  (i_arprot),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .o_rdata   (o_rdata),
    .o_rresp   (o_rresp),
    .o_rd_req  (rd_req),
    .o_rd_addr (rd_addr),
    .i_rd_gnt  (rd_gnt),
    .i_rd_resp (rd_resp),
    .i_rd_data (rd_data)
  );

  // Single SRAM port, ties alternate through an arb_pref_e register
  sram_bank_arb u_bank_arb (
    .clk       (clk),
    .rst       (rst),
    .i_wr_req  (wr_req),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_data),
    .i_wr_strb (wr_strb),
    .o_wr_gnt  (wr_gnt),
    .o_wr_resp (wr_resp),
    .i_rd_req  (rd_req),
    .i_rd_addr (rd_addr),
    .o_rd_gnt  (rd_gnt),
    .o_rd_resp (rd_resp),
    .o_rd_data (rd_data)
  );

endmodule

// ==== rtl/sram_bank_arb.sv ====
// Alternating priority arbiter, range decode, byte-masked SRAM array and read register
`include "axil_sram_params.svh"

module sram_bank_arb
  import axil_sram_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,

  // Write side
  input  logic                    i_wr_req,
  input  logic [`AXIL_ADDR_W-1:0] i_wr_addr,
  input  logic [`AXIL_DATA_W-1:0] i_wr_data,
  input  logic [`AXIL_STRB_W-1:0] i_wr_strb,
  output logic                    o_wr_gnt,
  output axil_resp_e              o_wr_resp,

  // Read side
  input  logic                    i_rd_req,
  input  logic [`AXIL_ADDR_W-1:0] i_rd_addr,
  output logic                    o_rd_gnt,
  output axil_resp_e              o_rd_resp,
  output logic [`AXIL_DATA_W-1:0] o_rd_data
);

  localparam int unsigned TOP_LSB = `SRAM_IDX_W + `SRAM_BYTE_OFFS;

  arb_pref_e              pref_q;
  logic                   wr_in_range;
  logic                   rd_in_range;
  logic [`SRAM_IDX_W-1:0] wr_idx;
  logic [`SRAM_IDX_W-1:0] rd_idx;
  logic [`AXIL_DATA_W-1:0] rd_data_q;

  logic [`AXIL_DATA_W-1:0] mem [0:(1 << `SRAM_IDX_W)-1];

  // Grant: a lone requester always wins, a tie goes to pref_q
  assign o_wr_gnt = i_wr_req && (!i_rd_req || (pref_q == PREF_WRITE));
  assign o_rd_gnt = i_rd_req && (!i_wr_req || (pref_q == PREF_READ));

  always_ff @(posedge clk) begin
    if (rst) begin
      pref_q <= PREF_READ;
    end else if (i_wr_req && i_rd_req) begin
      pref_q <= (pref_q == PREF_READ) ? PREF_WRITE : PREF_READ;
    end
  end

  // Anything at or above the array size decodes as DECERR
  assign wr_in_range = (i_wr_addr[`AXIL_ADDR_W-1:TOP_LSB] == '0);
  assign rd_in_range = (i_rd_addr[`AXIL_ADDR_W-1:TOP_LSB] == '0);

  assign o_wr_resp = wr_in_range ? RESP_OKAY : RESP_DECERR;
  assign o_rd_resp = rd_in_range ? RESP_OKAY : RESP_DECERR;

  assign wr_idx = i_wr_addr[TOP_LSB-1:`SRAM_BYTE_OFFS];
  assign rd_idx = i_rd_addr[TOP_LSB-1:`SRAM_BYTE_OFFS];

  // Byte lane write, one lane per strobe bit
  always_ff @(posedge clk) begin
    if (o_wr_gnt && wr_in_range) begin
      for (int b = 0; b < `AXIL_STRB_W; b++) begin
        if (i_wr_strb[b]) begin
          mem[wr_idx][8*b +: 8] <= i_wr_data[8*b +: 8];
        end
      end
    end
  end

  // Read word is held here until the next granted read
  always_ff @(posedge clk) begin
    if (o_rd_gnt) begin
      rd_data_q <= rd_in_range ? mem[rd_idx] : '0;
    end
  end

  assign o_rd_data = rd_data_q;

endmodule

// ==== rtl/axil_read_ctrl.sv ====
// AXI-lite read address and read data channel controller
`include "axil_sram_params.svh"

module axil_read_ctrl
  import axil_sram_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,

  // Read address channel
  input  logic                    i_arvalid,
  output logic                    o_arready,
  input  logic [`AXIL_ADDR_W-1:0] i_araddr,
  input  logic [2:0]              i_arprot,

  // Read data channel
  output logic                    o_rvalid,
  input  logic                    i_rready,
  output logic [`AXIL_DATA_W-1:0] o_rdata,
  output axil_resp_e              o_rresp,

  // Request to the SRAM arbiter
  output logic                    o_rd_req,
  output logic [`AXIL_ADDR_W-1:0] o_rd_addr,
  input  logic                    i_rd_gnt,
  input  axil_resp_e              i_rd_resp,
  input  logic [`AXIL_DATA_W-1:0] i_rd_data
);

  logic       rdy_q;
  logic       rvalid_q;
  axil_resp_e rresp_q;

  // A held R beat blocks the next request unless it leaves this cycle
  assign o_rd_req  = i_arvalid && (!rvalid_q || i_rready) && !rdy_q;
  assign o_rd_addr = i_araddr;

  assign o_arready = rdy_q;
  assign o_rvalid  = rvalid_q;
  assign o_rresp   = rresp_q;
  // Arbiter keeps its read word until the next granted read
  assign o_rdata   = i_rd_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      rdy_q    <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      rdy_q <= i_rd_gnt;
      if (i_rd_gnt) begin
        rvalid_q <= 1'b1;
      end else if (i_rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_rd_gnt) begin
      rresp_q <= i_rd_resp;
    end
  end

endmodule

// ==== rtl/axil_write_ctrl.sv ====
// AXI-lite write address, write data and write response channel controller
`include "axil_sram_params.svh"

module axil_write_ctrl
  import axil_sram_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,

  // Write address channel
  input  logic                    i_awvalid,
  output logic                    o_awready,
  input  logic [`AXIL_ADDR_W-1:0] i_awaddr,
  input  logic [2:0]              i_awprot,

  // Write data channel
  input  logic                    i_wvalid,
  output logic                    o_wready,
  input  logic [`AXIL_DATA_W-1:0] i_wdata,
  input  logic [`AXIL_STRB_W-1:0] i_wstrb,

  // Write response channel
  output logic                    o_bvalid,
  input  logic                    i_bready,
  output axil_resp_e              o_bresp,

  // Request to the SRAM arbiter
  output logic                    o_wr_req,
  output logic [`AXIL_ADDR_W-1:0] o_wr_addr,
  output logic [`AXIL_DATA_W-1:0] o_wr_data,
  output logic [`AXIL_STRB_W-1:0] o_wr_strb,
  input  logic                    i_wr_gnt,
  input  axil_resp_e              i_wr_resp
);

  logic       rdy_q;
  logic       bvalid_q;
  axil_resp_e bresp_q;

  // Request only once both AW and W are up and the B slot is free
  assign o_wr_req = i_awvalid && i_wvalid && (!bvalid_q || i_bready) && !rdy_q;

  assign o_wr_addr = i_awaddr;
  assign o_wr_data = i_wdata;
  assign o_wr_strb = i_wstrb;

  // AW and W are accepted together in the cycle after the grant
  assign o_awready = rdy_q;
  assign o_wready  = rdy_q;
  assign o_bvalid  = bvalid_q;
  assign o_bresp   = bresp_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      rdy_q    <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      rdy_q <= i_wr_gnt;
      if (i_wr_gnt) begin
        bvalid_q <= 1'b1;
      end else if (i_bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  // Response code is captured with the grant and held until taken
  always_ff @(posedge clk) begin
    if (i_wr_gnt) begin
      bresp_q <= i_wr_resp;
    end
  end

endmodule

// ==== rtl/axil_sram_pkg.sv ====
// Package with the AXI-lite response code and the arbiter priority types
package axil_sram_pkg;

  // AXI-lite response codes
  // SLVERR is listed for completeness, the slave never returns it
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } axil_resp_e;

  // Side that wins the next tie at the SRAM port
  typedef enum logic {
    PREF_WRITE = 1'b0,
    PREF_READ  = 1'b1
  } arb_pref_e;

endpackage

// ==== rtl/axil_sram_params.svh ====
// Bus width and SRAM sizing macros for the AXI-lite SRAM slave
`ifndef AXIL_SRAM_PARAMS_SVH
`define AXIL_SRAM_PARAMS_SVH

// AXI-lite address bus width
`define AXIL_ADDR_W 32

// AXI-lite data bus width
`define AXIL_DATA_W 64

// One strobe bit per data byte
`define AXIL_STRB_W 8

// Word index width, 256 words of 64 bits
`define SRAM_IDX_W 8

// Byte offset bits dropped to form the word index
`define SRAM_BYTE_OFFS 3

`endif
